//--- id_pkg.sv
package id_pkg;

    // **************************************************
    // register counts and widths
    // **************************************************
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    typedef logic [4:0]  arch_idx_t;
    typedef logic [5:0]  phys_idx_t;
    typedef logic [31:0] word_t;

    // **************************************************
    // instruction encodings
    // **************************************************
    // primary opcode, only the kept subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } op_e;

    // funct codes for r-type
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        op_e        op;
        arch_idx_t  rs;
        arch_idx_t  rt;
        arch_idx_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        op_e         op;
        arch_idx_t   rs;
        arch_idx_t   rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // same 32 bits, two views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } mips_instr_u;

    // **************************************************
    // pipeline records
    // **************************************************
    typedef struct packed {
        arch_idx_t  src_a;
        arch_idx_t  src_b;
        arch_idx_t  dest;
        logic       uses_b;
        logic       reg_write;
        alu_op_e    alu_op;
        logic [4:0] shamt;
        word_t      imm;
        logic       mem_read;
        logic       mem_write;
        word_t      pc;
    } decoded_t;

    // rename queue entry
    typedef struct packed {
        decoded_t  op;
        phys_idx_t phys_a;
        phys_idx_t phys_b;
        phys_idx_t phys_dest;
    } renamed_t;

    typedef struct packed {
        logic       valid;
        alu_op_e    alu_op;
        logic [4:0] shamt;
        word_t      operand_a;
        word_t      operand_b;
        word_t      store_data;
        arch_idx_t  dest;
        phys_idx_t  dest_phys;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        word_t      pc;
    } exe_packet_t;

    // execute broadcast and memory writeback share this
    typedef struct packed {
        logic      valid;
        arch_idx_t arch;
        phys_idx_t phys;
        word_t     value;
    } writeback_t;

endpackage

//--- fetch_queue.sv
`timescale 1ns/100ps

module fetch_queue #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 8
) (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage, no reset needed
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    // full doubles as the halt level upstream
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // **************************************************
    // pointers and occupancy
    // **************************************************
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // manual wrap, depth need not be a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // producer must respect full, consumer must respect empty
    a_no_overflow: assert property (@(posedge CLK) disable iff (!RESET) !(push && full));
    a_no_underflow: assert property (@(posedge CLK) disable iff (!RESET) !(pop && empty));

endmodule

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  id_pkg::mips_instr_u word,
    input  id_pkg::word_t       pc,
    output id_pkg::decoded_t    op
);

    import id_pkg::*;

    word_t sext_imm;
    word_t zext_imm;

    // both extensions from the i-format view
    assign sext_imm = {{16{word.i_fmt.imm16[15]}}, word.i_fmt.imm16};
    assign zext_imm = {16'h0000, word.i_fmt.imm16};

    always_comb begin
        op = '0;
        op.pc = pc;
        op.alu_op = ALU_ADD;
        // rs is read by everything except lui
        op.src_a = word.r_fmt.rs;

        case (word.i_fmt.op)
            OP_RTYPE: begin
                // r-type reads rt and writes rd
                op.src_b = word.r_fmt.rt;
                op.dest = word.r_fmt.rd;
                op.uses_b = 1'b1;
                op.reg_write = 1'b1;
                op.shamt = word.r_fmt.shamt;
                case (word.r_fmt.funct)
                    FN_ADDU: op.alu_op = ALU_ADD;
                    FN_SUBU: op.alu_op = ALU_SUB;
                    FN_AND:  op.alu_op = ALU_AND;
                    FN_OR:   op.alu_op = ALU_OR;
                    FN_XOR:  op.alu_op = ALU_XOR;
                    FN_SLT:  op.alu_op = ALU_SLT;
                    FN_SLL:  op.alu_op = ALU_SLL;
                    FN_SRL:  op.alu_op = ALU_SRL;
                    // unsupported funct, no-op
                    default: op.reg_write = 1'b0;
                endcase
            end
            // i-type writes rt, src_b stays $zero
            OP_ADDIU: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.imm = sext_imm;
            end
            OP_SLTI: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.alu_op = ALU_SLT;
                op.imm = sext_imm;
            end
            OP_ANDI: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.alu_op = ALU_AND;
                op.imm = zext_imm;
            end
            OP_ORI: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.alu_op = ALU_OR;
                op.imm = zext_imm;
            end
            OP_XORI: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.alu_op = ALU_XOR;
                op.imm = zext_imm;
            end
            OP_LUI: begin
                op.src_a = '0;
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.alu_op = ALU_LUI;
                op.imm = {word.i_fmt.imm16, 16'h0000};
            end
            // address is rs + sext imm for both memory ops
            OP_LW: begin
                op.dest = word.i_fmt.rt;
                op.reg_write = 1'b1;
                op.mem_read = 1'b1;
                op.imm = sext_imm;
            end
            OP_SW: begin
                // rt is the store data, no destination
                op.src_b = word.i_fmt.rt;
                op.mem_write = 1'b1;
                op.imm = sext_imm;
            end
            default: begin
                // unknown opcode, issues as a harmless no-op
                op.src_a = '0;
            end
        endcase

        // $zero is never renamed
        if (op.dest == '0) begin
            op.reg_write = 1'b0;
        end
    end

endmodule

//--- rename_map.sv
`timescale 1ns/100ps

module rename_map #(
    parameter int ARCH_REGS = id_pkg::ARCH_REGS,
    parameter int PHYS_REGS = id_pkg::PHYS_REGS
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  id_pkg::decoded_t     op,
    input  logic                 op_valid,
    input  logic                 queue_full,
    input  id_pkg::writeback_t   exe_wb,
    input  id_pkg::writeback_t   mem_wb,
    output id_pkg::renamed_t     renamed,
    output logic                 rename_fire,
    output logic [PHYS_REGS-1:0] ready
);

    import id_pkg::*;

    localparam int PTR_W = $clog2(PHYS_REGS);
    localparam int CNT_W = $clog2(PHYS_REGS + 1);
    localparam int FREE_INIT = PHYS_REGS - ARCH_REGS;

    // front map, retirement map
    phys_idx_t fmap [ARCH_REGS];
    phys_idx_t rmap [ARCH_REGS];

    // free list
    phys_idx_t free_fifo [PHYS_REGS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] free_count;

    logic [PHYS_REGS-1:0] busy;
    phys_idx_t alloc_phys;
    logic      alloc;
    logic      push_e;
    logic      push_m;
    phys_idx_t free_e;
    phys_idx_t free_m;

    // **************************************************
    // rename side
    // **************************************************
    assign alloc_phys = free_fifo[rd_ptr];
    // no free register needed when nothing is written
    assign rename_fire = op_valid && !queue_full && (!op.reg_write || free_count != '0);
    assign alloc = rename_fire && op.reg_write;

    always_comb begin
        renamed.op = op;
        renamed.phys_a = fmap[op.src_a];
        renamed.phys_b = fmap[op.src_b];
        renamed.phys_dest = op.reg_write ? alloc_phys : '0;
    end

    // busy, with same-cycle writeback bypass
    always_comb begin
        ready = ~busy;
        if (exe_wb.valid) begin
            ready[exe_wb.phys] = 1'b1;
        end
        if (mem_wb.valid) begin
            ready[mem_wb.phys] = 1'b1;
        end
    end

    // **************************************************
    // retirement side
    // **************************************************
    assign push_e = exe_wb.valid && exe_wb.arch != '0;
    assign push_m = mem_wb.valid && mem_wb.arch != '0;
    assign free_e = rmap[exe_wb.arch];
    // exe taken as older when both hit one arch reg
    assign free_m = (push_e && exe_wb.arch == mem_wb.arch) ? exe_wb.phys : rmap[mem_wb.arch];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            // identity maps, upper half free
            for (int i = 0; i < ARCH_REGS; i++) begin
                fmap[i] <= phys_idx_t'(i);
                rmap[i] <= phys_idx_t'(i);
            end
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_fifo[i] <= phys_idx_t'(ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= PTR_W'(FREE_INIT);
            free_count <= CNT_W'(FREE_INIT);
            busy <= '0;
        end else begin
            if (alloc) begin
                fmap[op.dest] <= alloc_phys;
                busy[alloc_phys] <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (exe_wb.valid) begin
                busy[exe_wb.phys] <= 1'b0;
            end
            if (mem_wb.valid) begin
                busy[mem_wb.phys] <= 1'b0;
            end
            // displaced mappings go back on the free list
            if (push_e) begin
                rmap[exe_wb.arch] <= exe_wb.phys;
                free_fifo[wr_ptr] <= free_e;
            end
            if (push_m) begin
                rmap[mem_wb.arch] <= mem_wb.phys;
                free_fifo[wr_ptr + PTR_W'(push_e)] <= free_m;
            end
            wr_ptr <= wr_ptr + PTR_W'(push_e) + PTR_W'(push_m);
            free_count <= free_count + CNT_W'(push_e) + CNT_W'(push_m) - CNT_W'(alloc);
        end
    end

    // a freed register has had its own writeback
    a_free_not_busy: assert property (@(posedge CLK) disable iff (!RESET)
        !(push_e && !ready[free_e]) && !(push_m && !ready[free_m]));

endmodule

//--- phys_regfile.sv
`timescale 1ns/100ps

module phys_regfile #(
    parameter int PHYS_REGS = id_pkg::PHYS_REGS
) (
    input  logic               CLK,
    input  logic               RESET,
    input  id_pkg::writeback_t exe_wb,
    input  id_pkg::writeback_t mem_wb,
    input  id_pkg::phys_idx_t  rd_a,
    input  id_pkg::phys_idx_t  rd_b,
    output id_pkg::word_t      val_a,
    output id_pkg::word_t      val_b
);

    import id_pkg::*;

    word_t regs [PHYS_REGS];

    // two independent write ports, no arbitration
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            // architectural state starts at zero
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (exe_wb.valid) begin
                regs[exe_wb.phys] <= exe_wb.value;
            end
            if (mem_wb.valid) begin
                regs[mem_wb.phys] <= mem_wb.value;
            end
        end
    end

    // write-through bypass on both reads
    assign val_a = (exe_wb.valid && exe_wb.phys == rd_a) ? exe_wb.value :
                   (mem_wb.valid && mem_wb.phys == rd_a) ? mem_wb.value : regs[rd_a];
    assign val_b = (exe_wb.valid && exe_wb.phys == rd_b) ? exe_wb.value :
                   (mem_wb.valid && mem_wb.phys == rd_b) ? mem_wb.value : regs[rd_b];

    // each physical register has a single producer
    a_port_clash: assert property (@(posedge CLK) disable iff (!RESET)
        !(exe_wb.valid && mem_wb.valid && exe_wb.phys == mem_wb.phys));

endmodule

//--- issue_stage.sv
`timescale 1ns/100ps

module issue_stage #(
    parameter int PHYS_REGS = id_pkg::PHYS_REGS
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  id_pkg::renamed_t     head,
    input  logic                 empty,
    input  logic [PHYS_REGS-1:0] ready,
    input  id_pkg::word_t        val_a,
    input  id_pkg::word_t        val_b,
    output logic                 pop,
    output id_pkg::phys_idx_t    rd_a,
    output id_pkg::phys_idx_t    rd_b,
    output id_pkg::exe_packet_t  issue
);

    import id_pkg::*;

    exe_packet_t next_pkt;

    // register file reads straight from the queue head
    assign rd_a = head.phys_a;
    assign rd_b = head.phys_b;

    // in order, head only; unused sources sit on phys 0
    assign pop = !empty && ready[head.phys_a] && ready[head.phys_b];

    // **************************************************
    // packet assembly
    // **************************************************
    always_comb begin
        next_pkt.valid = 1'b1;
        next_pkt.alu_op = head.op.alu_op;
        next_pkt.shamt = head.op.shamt;
        next_pkt.operand_a = val_a;
        // register or immediate
        next_pkt.operand_b = head.op.uses_b ? val_b : head.op.imm;
        // rt value for sw
        next_pkt.store_data = val_b;
        next_pkt.dest = head.op.dest;
        next_pkt.dest_phys = head.phys_dest;
        next_pkt.reg_write = head.op.reg_write;
        next_pkt.mem_read = head.op.mem_read;
        next_pkt.mem_write = head.op.mem_write;
        next_pkt.pc = head.op.pc;
    end

    // one-cycle valid per popped entry
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            issue <= '0;
        end else if (pop) begin
            issue <= next_pkt;
        end else begin
            issue.valid <= 1'b0;
        end
    end

endmodule

//--- id_top.sv
`timescale 1ns/100ps

module id_top #(
    parameter int ARCH_REGS = id_pkg::ARCH_REGS,
    parameter int PHYS_REGS = id_pkg::PHYS_REGS,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                instr_valid,
    input  id_pkg::word_t       instr,
    input  id_pkg::word_t       instr_pc,
    input  id_pkg::writeback_t  exe_wb,
    input  id_pkg::writeback_t  mem_wb,
    output logic                halt,
    output id_pkg::exe_packet_t issue
);

    import id_pkg::*;

    // **************************************************
    // fetch buffer and decode
    // **************************************************
    logic [2*$bits(word_t)-1:0] buf_head;
    logic buf_empty;
    decoded_t decoded;
    renamed_t renamed;
    logic rename_fire;

    // pc in the upper word, halt is the full level
    fetch_queue #(.WIDTH(2*$bits(word_t)), .DEPTH(QUEUE_DEPTH)) u_fetch_buf (
        .CLK(CLK), .RESET(RESET),
        .push(instr_valid), .push_data({instr_pc, instr}),
        .pop(rename_fire), .head(buf_head),
        .empty(buf_empty), .full(halt)
    );

    instr_decoder u_decoder (
        .word(buf_head[$bits(word_t)-1:0]),
        .pc(buf_head[2*$bits(word_t)-1:$bits(word_t)]),
        .op(decoded)
    );

    // **************************************************
    // rename and rename queue
    // **************************************************
    renamed_t rq_head;
    logic rq_empty;
    logic rq_full;
    logic rq_pop;
    logic [PHYS_REGS-1:0] ready;

    rename_map #(.ARCH_REGS(ARCH_REGS), .PHYS_REGS(PHYS_REGS)) u_rename (
        .CLK(CLK), .RESET(RESET),
        .op(decoded), .op_valid(!buf_empty), .queue_full(rq_full),
        .exe_wb(exe_wb), .mem_wb(mem_wb),
        .renamed(renamed), .rename_fire(rename_fire), .ready(ready)
    );

    fetch_queue #(.WIDTH($bits(renamed_t)), .DEPTH(QUEUE_DEPTH)) u_rename_q (
        .CLK(CLK), .RESET(RESET),
        .push(rename_fire), .push_data(renamed),
        .pop(rq_pop), .head(rq_head),
        .empty(rq_empty), .full(rq_full)
    );

    // **************************************************
    // register file and issue
    // **************************************************
    phys_idx_t rd_a;
    phys_idx_t rd_b;
    word_t val_a;
    word_t val_b;

    phys_regfile #(.PHYS_REGS(PHYS_REGS)) u_regfile (
        .CLK(CLK), .RESET(RESET),
        .exe_wb(exe_wb), .mem_wb(mem_wb),
        .rd_a(rd_a), .rd_b(rd_b), .val_a(val_a), .val_b(val_b)
    );

    issue_stage #(.PHYS_REGS(PHYS_REGS)) u_issue (
        .CLK(CLK), .RESET(RESET),
        .head(rq_head), .empty(rq_empty), .ready(ready),
        .val_a(val_a), .val_b(val_b),
        .pop(rq_pop), .rd_a(rd_a), .rd_b(rd_b), .issue(issue)
    );

endmodule

//--- tb_id_ref.svh
// **************************************************
// reference model of the decode and rename front end
// **************************************************

// architectural register file in program order
word_t ref_regs [32];

// free list and retirement map as seen from the writeback ports
phys_idx_t free_tags [$];
phys_idx_t retire_map [32];

// load data depends on every address bit
function automatic word_t load_value(input word_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h3c96_a5e1 ^ (addr << 3);
endfunction

// identity map, upper half free in ascending order
function automatic void reset_tag_model();
    free_tags.delete();
    for (int i = 0; i < 32; i++) begin
        retire_map[i] = phys_idx_t'(i);
        free_tags.push_back(phys_idx_t'(32 + i));
    end
endfunction

// writers take tags in program order, others carry phys 0
function automatic phys_idx_t next_tag(input logic reg_write);
    phys_idx_t t;
    t = '0;
    if (reg_write) begin
        t = free_tags.pop_front();
    end
    return t;
endfunction

// a writeback frees the tag it displaces from the retirement map
function automatic void retire_tag(input writeback_t wb);
    free_tags.push_back(retire_map[wb.arch]);
    retire_map[wb.arch] = wb.phys;
endfunction

// expected packet and result of one instruction
function automatic void ref_eval(input word_t w, input word_t pc,
                                 output exe_packet_t p, output word_t res);
    logic [5:0] opc;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [15:0] imm;
    word_t simm;
    word_t zimm;
    opc = w[31:26];
    rs = w[25:21];
    rt = w[20:16];
    imm = w[15:0];
    simm = {{16{imm[15]}}, imm};
    zimm = {16'h0000, imm};
    p = '0;
    p.valid = 1'b1;
    p.pc = pc;
    p.alu_op = ALU_ADD;
    p.operand_a = ref_regs[rs];
    p.dest = rt;
    p.operand_b = simm;
    case (opc)
        6'h00: begin
            // r-type reads rt and writes rd
            p.operand_b = ref_regs[rt];
            p.store_data = ref_regs[rt];
            p.dest = w[15:11];
            p.shamt = w[10:6];
            case (w[5:0])
                6'h23: p.alu_op = ALU_SUB;
                6'h24: p.alu_op = ALU_AND;
                6'h25: p.alu_op = ALU_OR;
                6'h26: p.alu_op = ALU_XOR;
                6'h2a: p.alu_op = ALU_SLT;
                6'h00: p.alu_op = ALU_SLL;
                6'h02: p.alu_op = ALU_SRL;
                default: p.alu_op = ALU_ADD;
            endcase
        end
        6'h09: p.alu_op = ALU_ADD;
        6'h0a: p.alu_op = ALU_SLT;
        6'h0c: begin
            p.alu_op = ALU_AND;
            p.operand_b = zimm;
        end
        6'h0d: begin
            p.alu_op = ALU_OR;
            p.operand_b = zimm;
        end
        6'h0e: begin
            p.alu_op = ALU_XOR;
            p.operand_b = zimm;
        end
        6'h0f: begin
            // lui ignores rs
            p.alu_op = ALU_LUI;
            p.operand_a = '0;
            p.operand_b = {imm, 16'h0000};
        end
        6'h23: p.mem_read = 1'b1;
        6'h2b: begin
            // store data from rt and no destination
            p.mem_write = 1'b1;
            p.store_data = ref_regs[rt];
            p.dest = '0;
        end
        default: begin
            // unknown opcode issues as a no-op
            p.operand_a = '0;
            p.operand_b = '0;
            p.dest = '0;
        end
    endcase
    p.reg_write = (p.dest != '0);

    case (p.alu_op)
        ALU_SUB: res = p.operand_a - p.operand_b;
        ALU_AND: res = p.operand_a & p.operand_b;
        ALU_OR:  res = p.operand_a | p.operand_b;
        ALU_XOR: res = p.operand_a ^ p.operand_b;
        ALU_SLT: res = ($signed(p.operand_a) < $signed(p.operand_b)) ? 32'd1 : 32'd0;
        ALU_SLL: res = p.operand_b << p.shamt;
        ALU_SRL: res = p.operand_b >> p.shamt;
        ALU_LUI: res = p.operand_b;
        default: res = p.operand_a + p.operand_b;
    endcase
    if (p.mem_read) begin
        res = load_value(res);
    end
    if (p.reg_write) begin
        ref_regs[p.dest] = res;
    end
endfunction

//--- tb_id.sv
`timescale 1ns/100ps

module tb_id;

    import id_pkg::*;

    `include "tb_id_ref.svh"

    localparam int N_INSTR = 121;
    localparam int LIMIT = 20 * N_INSTR + 200;

    logic CLK;
    logic RESET;
    logic instr_valid;
    word_t instr;
    word_t instr_pc;
    writeback_t exe_wb;
    writeback_t mem_wb;
    logic halt;
    exe_packet_t issue;

    // expected packets and results in program order
    exe_packet_t exp_q [$];
    word_t res_q [$];
    // writebacks owed in issue order
    writeback_t wb_q [$];
    logic load_q [$];
    logic hold_wb;
    int wait_cnt;
    int seed;
    int errors;
    int checks;
    int cycles;
    word_t next_pc;

    id_top #(.ARCH_REGS(32), .PHYS_REGS(64), .QUEUE_DEPTH(8)) UUT (
        .CLK(CLK), .RESET(RESET), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .exe_wb(exe_wb), .mem_wb(mem_wb),
        .halt(halt), .issue(issue)
    );

    always #2 CLK = ~CLK;

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_packet(input string name, input exe_packet_t exp,
                                input exe_packet_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_halt(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    // present one word once halt is low
    task automatic send_instr(input word_t w);
        exe_packet_t p;
        word_t r;
        @(posedge CLK);
        while (halt) begin
            @(posedge CLK);
        end
        instr_valid <= 1'b1;
        instr <= w;
        instr_pc <= next_pc;
        ref_eval(w, next_pc, p, r);
        exp_q.push_back(p);
        res_q.push_back(r);
        next_pc = next_pc + 4;
        @(posedge CLK);
        instr_valid <= 1'b0;
    endtask

    // wait until every packet is compared and every writeback sent
    task automatic wait_drain();
        while (exp_q.size() > 0 || wb_q.size() > 0) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
    endtask

    function automatic word_t r_word(input int rs, input int rt, input int rd,
                                     input int sh, input logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t i_word(input logic [5:0] opc, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {opc, 5'(rs), 5'(rt), imm};
    endfunction

    // random alu instruction over registers 0 to 7
    task automatic random_alu_instr();
        logic [5:0] fns [8] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00, 6'h02};
        logic [5:0] ops [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        int k;
        k = $unsigned($random(seed)) % 14;
        if (k < 8) begin
            send_instr(r_word($unsigned($random(seed)) % 8, $unsigned($random(seed)) % 8,
                              $unsigned($random(seed)) % 8, $random(seed), fns[k]));
        end else begin
            send_instr(i_word(ops[k-8], $unsigned($random(seed)) % 8,
                              $unsigned($random(seed)) % 8, $random(seed)));
        end
    endtask

    // **************************************************
    // compare and writeback responder
    // **************************************************
    always @(posedge CLK) begin
        exe_packet_t e;
        writeback_t wb;
        if (RESET && issue.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("issue seen with no instruction outstanding, pc %h", issue.pc);
            end else begin
                e = exp_q.pop_front();
                // tags leave the free list in allocation order
                e.dest_phys = next_tag(e.reg_write);
                check_packet($sformatf("packet pc %h", e.pc), e, issue);
                wb.valid = 1'b1;
                wb.arch = e.dest;
                wb.phys = e.dest_phys;
                wb.value = res_q.pop_front();
                if (e.reg_write) begin
                    wb_q.push_back(wb);
                    load_q.push_back(e.mem_read);
                end
            end
        end
        exe_wb.valid <= 1'b0;
        mem_wb.valid <= 1'b0;
        if (!hold_wb && wb_q.size() > 0) begin
            if (wait_cnt == 0) begin
                wb = wb_q.pop_front();
                retire_tag(wb);
                if (load_q.pop_front()) begin
                    mem_wb <= wb;
                end else begin
                    exe_wb <= wb;
                end
                wait_cnt <= $unsigned($random(seed)) % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // run limit
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, %0d packets still expected", cycles,
                     exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // **************************************************
    // stimulus
    // **************************************************
    initial begin
        CLK = 1'b0;
        RESET = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        instr_pc = '0;
        exe_wb = '0;
        mem_wb = '0;
        hold_wb = 1'b0;
        wait_cnt = 0;
        seed = 32'h4bd0;
        errors = 0;
        checks = 0;
        cycles = 0;
        next_pc = 32'h0040_0000;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        reset_tag_model();
        repeat (8) @(posedge CLK);
        RESET <= 1'b1;
        @(posedge CLK);
        check_halt("halt after reset", 1'b0, halt);
        check_packet("issue after reset", '0, issue);

        // zero operands first and then a random mix
        send_instr(r_word(3, 4, 5, 0, 6'h21));
        send_instr(i_word(6'h0e, 6, 7, 16'h8001));
        for (int i = 0; i < 60; i++) begin
            random_alu_instr();
        end
        // dependent chain
        send_instr(i_word(6'h09, 0, 1, 16'hfff3));
        send_instr(r_word(1, 1, 2, 0, 6'h21));
        send_instr(r_word(2, 1, 3, 0, 6'h23));
        send_instr(r_word(0, 3, 4, 5, 6'h00));
        send_instr(i_word(6'h0d, 4, 4, 16'h9000));
        // $zero as destination and source
        send_instr(i_word(6'h09, 5, 0, 16'h0007));
        send_instr(r_word(0, 0, 6, 0, 6'h25));
        // memory ops and a consumer of the load
        send_instr(i_word(6'h2b, 2, 3, 16'h0010));
        send_instr(i_word(6'h23, 2, 4, 16'hfff0));
        send_instr(r_word(4, 4, 5, 0, 6'h21));
        send_instr(i_word(6'h23, 5, 7, 16'h0004));

        // with writebacks held the free list runs dry after 32 renames
        wait_drain();
        hold_wb <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (i == 39) begin
                @(posedge CLK);
                check_halt("halt with one buffer slot left", 1'b0, halt);
            end
            send_instr(i_word(6'h09, 0, 1 + i % 7, 16'(i * 911)));
        end
        @(posedge CLK);
        check_halt("halt with free list and buffer exhausted", 1'b1, halt);

        // dependent tail waits on halt until writebacks resume
        fork
            begin
                for (int i = 40; i < 48; i++) begin
                    send_instr(i_word(6'h09, 1 + (i + 6) % 7, 1 + i % 7, 16'(i)));
                end
            end
            begin
                repeat (10) @(posedge CLK);
                hold_wb <= 1'b0;
            end
        join

        wait_drain();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
id_pkg.sv
fetch_queue.sv
instr_decoder.sv
rename_map.sv
phys_regfile.sv
issue_stage.sv
id_top.sv
tb_id.sv
